//--- rtl/dcd_params.svh
/* Channel count, register map, field positions and values, default tune and settle count
   for the DCD calibration controller */
`ifndef DCD_PARAMS_SVH
`define DCD_PARAMS_SVH

// Channels visited, 0 to N-1
`define DCD_NUM_CHANNELS    6

// Register addresses, one set per channel
`define DCD_ADDR_REQUEST    12'h000
`define DCD_ADDR_ID         12'h001
`define DCD_ADDR_CLK_MON    12'h002
`define DCD_ADDR_LST        12'h003
`define DCD_ADDR_TUNE       12'h004

// Bit and field positions in 16-bit registers
`define DCD_REQUEST_BIT     2
`define DCD_ID_TX_BIT       1
`define DCD_CLK_MON_BIT     10
`define DCD_LST_LO          4
`define DCD_LST_HI          7
`define DCD_TUNE_LO         8
`define DCD_TUNE_HI         10

// Field values
`define DCD_LST_ON          4'b1100
`define DCD_LST_OFF         4'b0000
`define DCD_TUNE_DEFAULT    3'd3

// Wait before each comparator sample
`define DCD_SETTLE_CYCLES   4

`endif

//--- rtl/dcd_bus_pkg.sv
/* Register bus types: opcode and the calibration steps handled by the bus master */
`default_nettype none

package dcd_bus_pkg;

  // Bus operation
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } dcd_opcode_e;

  // Steps the sequencer hands to the bus master
  typedef enum logic [2:0] {
    check_request = 3'd0,
    check_id      = 3'd1,
    set_clk_mon   = 3'd2,
    clear_clk_mon = 3'd3,
    set_lst       = 3'd4,
    clear_lst     = 3'd5,
    write_tune    = 3'd6
  } dcd_step_e;

endpackage

`default_nettype wire

//--- rtl/dcd_cal_pkg.sv
/* Calibration types: sequencer states, tune value and channel number */
`default_nettype none

package dcd_cal_pkg;

  // Per-channel sequencer states
  typedef enum logic [3:0] {
    st_idle          = 4'd0,
    st_check_req     = 4'd1,
    st_check_id      = 4'd2,
    st_set_clk_mon   = 4'd3,
    st_set_lst       = 4'd4,
    st_write_tune    = 4'd5,
    st_settle        = 4'd6,
    st_sample        = 4'd7,
    st_clear_clk_mon = 4'd8,
    st_clear_lst     = 4'd9,
    st_next_chan     = 4'd10,
    st_done          = 4'd11
  } dcd_state_e;

  typedef logic [2:0] dcd_tune_t;
  typedef logic [9:0] dcd_chan_t;

endpackage

`default_nettype wire

//--- rtl/dcd_step_if.sv
/* Register step request from the sequencer to the bus master */
`timescale 1ns/10ps
`default_nettype none

interface dcd_step_if
  import dcd_bus_pkg::*;
  import dcd_cal_pkg::*;
();

  logic      start;
  dcd_step_e step;
  dcd_tune_t tune;
  logic      finished;
  // Valid with finished, check steps only
  logic      check_ok;

  modport sequencer (
    output start, step, tune,
    input  finished, check_ok
  );

  modport master (
    input  start, step, tune,
    output finished, check_ok
  );

endinterface

`default_nettype wire

//--- rtl/dcd_tune_if.sv
/* Control and result signals between the sequencer and the tune search */
`timescale 1ns/10ps
`default_nettype none

interface dcd_tune_if
  import dcd_cal_pkg::*;
();

  logic      init;
  logic      sample;
  dcd_tune_t tune;
  logic      decided;
  logic      settled;
  dcd_tune_t final_tune;

  modport sequencer (output init, sample, input tune, decided, settled, final_tune);

  modport search (input init, sample, output tune, decided, settled, final_tune);

endinterface

`default_nettype wire

//--- rtl/dcd_sequencer.sv
/* Per-channel calibration FSM with channel counter, lock and busy outputs */
`timescale 1ns/10ps
`default_nettype none
`include "dcd_params.svh"

module dcd_sequencer
  import dcd_bus_pkg::*;
  import dcd_cal_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          ctrl_chan_err,
  output dcd_chan_t     ctrl_chan,
  output logic          ctrl_lock,
  output logic          user_busy,
  dcd_step_if.sequencer step,
  dcd_tune_if.sequencer tune
);

  dcd_state_e state;
  logic       issued;
  logic       start_q;
  dcd_step_e  step_q;
  dcd_tune_t  tune_q;
  logic       final_write;
  logic [7:0] settle_cnt;
  logic       last_chan;
  logic       skip;

  function automatic dcd_step_e step_for(dcd_state_e s);
    case (s)
      st_check_id:      return check_id;
      st_set_clk_mon:   return set_clk_mon;
      st_set_lst:       return set_lst;
      st_write_tune:    return write_tune;
      st_clear_clk_mon: return clear_clk_mon;
      st_clear_lst:     return clear_lst;
      default:          return check_request;
    endcase
  endfunction

  assign last_chan = (ctrl_chan == dcd_chan_t'(`DCD_NUM_CHANNELS - 1));
  assign skip      = ctrl_chan_err || !step.check_ok;

  assign step.start = start_q;
  assign step.step  = step_q;
  assign step.tune  = tune_q;

  // Search restarts as the test mode write completes
  assign tune.init   = (state == st_set_lst) && issued && step.finished;
  assign tune.sample = (state == st_settle) && (settle_cnt == '0);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state       <= st_idle;
      issued      <= 1'b0;
      start_q     <= 1'b0;
      step_q      <= check_request;
      tune_q      <= '0;
      final_write <= 1'b0;
      settle_cnt  <= '0;
      ctrl_chan   <= '0;
      ctrl_lock   <= 1'b0;
      user_busy   <= 1'b1;
    end else begin
      start_q <= 1'b0;
      case (state)
        st_idle: state <= st_check_req;

        st_check_req, st_check_id, st_set_clk_mon, st_set_lst,
        st_write_tune, st_clear_clk_mon, st_clear_lst: begin
          if (!issued) begin
            issued  <= 1'b1;
            start_q <= 1'b1;
            step_q  <= step_for(state);
            tune_q  <= final_write ? tune.final_tune : tune.tune;
            if (state == st_set_clk_mon) begin
              ctrl_lock <= 1'b1;
            end
          end else if (step.finished) begin
            issued <= 1'b0;
            case (state)
              st_check_req:     state <= skip ? st_next_chan : st_check_id;
              st_check_id:      state <= skip ? st_next_chan : st_set_clk_mon;
              st_set_clk_mon:   state <= st_set_lst;
              st_set_lst:       state <= st_write_tune;
              st_write_tune: begin
                final_write <= 1'b0;
                settle_cnt  <= 8'(`DCD_SETTLE_CYCLES - 1);
                state       <= final_write ? st_clear_clk_mon : st_settle;
              end
              st_clear_clk_mon: state <= st_clear_lst;
              default: begin
                ctrl_lock <= 1'b0;
                state     <= st_next_chan;
              end
            endcase
          end
        end

        // Comparator settle time after a tune write
        st_settle: begin
          if (settle_cnt == '0) begin
            state <= st_sample;
          end else begin
            settle_cnt <= settle_cnt - 8'd1;
          end
        end

        st_sample: begin
          if (tune.decided) begin
            final_write <= tune.settled;
            state       <= st_write_tune;
          end
        end

        st_next_chan: begin
          if (last_chan) begin
            user_busy <= 1'b0;
            state     <= st_done;
          end else begin
            ctrl_chan <= ctrl_chan + dcd_chan_t'(1);
            state     <= st_check_req;
          end
        end

        st_done: state <= st_done;

        default: state <= st_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcd_tune_search.sv
/* Comparator sampling, level change detection and tune sweep */
`timescale 1ns/10ps
`default_nettype none
`include "dcd_params.svh"

module dcd_tune_search
  import dcd_cal_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        lch_atbout,
  dcd_tune_if.search  tune
);

  logic      cmp_q;
  logic      first_q;
  logic      level_q;
  dcd_tune_t tune_q;
  dcd_tune_t prev_q;
  dcd_tune_t final_q;
  logic      decided_q;
  logic      settled_q;
  logic      level;
  logic      at_end;

  assign tune.tune       = tune_q;
  assign tune.decided    = decided_q;
  assign tune.settled    = settled_q;
  assign tune.final_tune = final_q;

  // First sample fixes the sweep direction, high sweeps down
  assign level  = first_q ? cmp_q : level_q;
  assign at_end = level ? (tune_q == dcd_tune_t'(0)) : (tune_q == dcd_tune_t'(7));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cmp_q     <= 1'b0;
      first_q   <= 1'b1;
      level_q   <= 1'b0;
      tune_q    <= `DCD_TUNE_DEFAULT;
      prev_q    <= `DCD_TUNE_DEFAULT;
      final_q   <= `DCD_TUNE_DEFAULT;
      decided_q <= 1'b0;
      settled_q <= 1'b0;
    end else begin
      cmp_q     <= lch_atbout;
      decided_q <= 1'b0;
      if (tune.init) begin
        first_q <= 1'b1;
        tune_q  <= `DCD_TUNE_DEFAULT;
        prev_q  <= `DCD_TUNE_DEFAULT;
      end else if (tune.sample) begin
        decided_q <= 1'b1;
        first_q   <= 1'b0;
        level_q   <= level;
        if (!first_q && (cmp_q != level_q)) begin
          // Level changed, go back one step
          settled_q <= 1'b1;
          final_q   <= prev_q;
        end else if (at_end) begin
          settled_q <= 1'b1;
          final_q   <= tune_q;
        end else begin
          settled_q <= 1'b0;
          prev_q    <= tune_q;
          tune_q    <= level ? tune_q - dcd_tune_t'(1) : tune_q + dcd_tune_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcd_bus_master.sv
/* Read and read-modify-write engine for the register bus */
`timescale 1ns/10ps
`default_nettype none
`include "dcd_params.svh"

module dcd_bus_master
  import dcd_bus_pkg::*;
  import dcd_cal_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        ctrl_done,
  input  logic [15:0] ctrl_rdata,
  output logic        ctrl_go,
  output logic [11:0] ctrl_addr,
  output dcd_opcode_e ctrl_opcode,
  output logic [15:0] ctrl_wdata,
  dcd_step_if.master  step
);

  dcd_step_e cur_step;
  dcd_tune_t cur_tune;
  logic      rd_active;
  logic      wr_arm;
  logic      wr_active;
  logic      finished_q;
  logic      check_ok_q;
  logic      is_check;

  function automatic logic [11:0] addr_of(dcd_step_e s);
    case (s)
      check_request:              return `DCD_ADDR_REQUEST;
      check_id:                   return `DCD_ADDR_ID;
      set_clk_mon, clear_clk_mon: return `DCD_ADDR_CLK_MON;
      set_lst, clear_lst:         return `DCD_ADDR_LST;
      default:                    return `DCD_ADDR_TUNE;
    endcase
  endfunction

  // Replace only the target field of the read data
  function automatic logic [15:0] merge(dcd_step_e s, dcd_tune_t t, logic [15:0] d);
    logic [15:0] w;
    w = d;
    case (s)
      set_clk_mon:   w[`DCD_CLK_MON_BIT] = 1'b1;
      clear_clk_mon: w[`DCD_CLK_MON_BIT] = 1'b0;
      set_lst:       w[`DCD_LST_HI:`DCD_LST_LO] = `DCD_LST_ON;
      clear_lst:     w[`DCD_LST_HI:`DCD_LST_LO] = `DCD_LST_OFF;
      write_tune:    w[`DCD_TUNE_HI:`DCD_TUNE_LO] = t;
      default:       w = d;
    endcase
    return w;
  endfunction

  assign is_check      = (cur_step == check_request) || (cur_step == check_id);
  assign step.finished = finished_q;
  assign step.check_ok = check_ok_q;

  always_ff @(posedge clk) begin
    if (step.start) begin
      cur_step  <= step.step;
      cur_tune  <= step.tune;
      ctrl_addr <= addr_of(step.step);
    end
    if (rd_active && ctrl_done && !is_check) begin
      ctrl_wdata <= merge(cur_step, cur_tune, ctrl_rdata);
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ctrl_go     <= 1'b0;
      ctrl_opcode <= op_read;
      rd_active   <= 1'b0;
      wr_arm      <= 1'b0;
      wr_active   <= 1'b0;
      finished_q  <= 1'b0;
      check_ok_q  <= 1'b0;
    end else begin
      ctrl_go    <= 1'b0;
      finished_q <= 1'b0;
      if (step.start) begin
        ctrl_opcode <= op_read;
        ctrl_go     <= 1'b1;
        rd_active   <= 1'b1;
      end
      if (rd_active && ctrl_done) begin
        rd_active <= 1'b0;
        if (is_check) begin
          finished_q <= 1'b1;
          check_ok_q <= (cur_step == check_request) ? ctrl_rdata[`DCD_REQUEST_BIT]
                                                    : ctrl_rdata[`DCD_ID_TX_BIT];
        end else begin
          wr_arm <= 1'b1;
        end
      end
      // Write data settles one cycle before its go
      if (wr_arm) begin
        wr_arm      <= 1'b0;
        wr_active   <= 1'b1;
        ctrl_opcode <= op_write;
        ctrl_go     <= 1'b1;
      end
      if (wr_active && ctrl_done) begin
        wr_active  <= 1'b0;
        finished_q <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dcd_calibration_top.sv
/* DCD calibration top level, sequencer, tune search and bus master
   joined by the step and tune interfaces */
`timescale 1ns/10ps
`default_nettype none

module dcd_calibration_top
  import dcd_bus_pkg::*;
  import dcd_cal_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        lch_atbout,
  input  logic        ctrl_done,
  input  logic        ctrl_chan_err,
  input  logic [15:0] ctrl_rdata,
  output logic        ctrl_go,
  output logic        ctrl_lock,
  output dcd_chan_t   ctrl_chan,
  output logic [11:0] ctrl_addr,
  output dcd_opcode_e ctrl_opcode,
  output logic [15:0] ctrl_wdata,
  output logic        user_busy
);

  dcd_step_if step_bus ();
  dcd_tune_if tune_bus ();

  dcd_sequencer sequencer_i (
    .clk           (clk),
    .reset         (reset),
    .ctrl_chan_err (ctrl_chan_err),
    .ctrl_chan     (ctrl_chan),
    .ctrl_lock     (ctrl_lock),
    .user_busy     (user_busy),
    .step          (step_bus.sequencer),
    .tune          (tune_bus.sequencer)
  );

  dcd_tune_search tune_search_i (
    .clk        (clk),
    .reset      (reset),
    .lch_atbout (lch_atbout),
    .tune       (tune_bus.search)
  );

  dcd_bus_master bus_master_i (
    .clk         (clk),
    .reset       (reset),
    .ctrl_done   (ctrl_done),
    .ctrl_rdata  (ctrl_rdata),
    .ctrl_go     (ctrl_go),
    .ctrl_addr   (ctrl_addr),
    .ctrl_opcode (ctrl_opcode),
    .ctrl_wdata  (ctrl_wdata),
    .step        (step_bus.master)
  );

endmodule

`default_nettype wire

//--- dv/dcd_clock_gen.sv
/* Testbench clock and power-on reset generator */
`timescale 1ns/10ps
`default_nettype none

module dcd_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Release on a falling edge like every other input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

//--- dv/dcd_tb.sv
/* DCD calibration testbench with register bus model, comparator model,
   per-channel table with expected tune values, checks and watchdog */
`timescale 1ns/10ps
`default_nettype none
`include "dcd_params.svh"

module dcd_tb
  import dcd_bus_pkg::*;
  import dcd_cal_pkg::*;
();

  localparam int NUM_REGS        = 5;
  localparam int IDX_REQUEST     = int'(`DCD_ADDR_REQUEST);
  localparam int IDX_ID          = int'(`DCD_ADDR_ID);
  localparam int IDX_CLK_MON     = int'(`DCD_ADDR_CLK_MON);
  localparam int IDX_LST         = int'(`DCD_ADDR_LST);
  localparam int IDX_TUNE        = int'(`DCD_ADDR_TUNE);
  localparam int QUIET_CYCLES    = 100;
  localparam int WATCHDOG_CYCLES = `DCD_NUM_CHANNELS * 40 * 10;

  typedef struct packed {
    logic       request;
    logic       id;
    logic       chan_err;
    logic [2:0] threshold;
    logic       stuck;
    logic [2:0] exp_tune;
  } row_t;

  logic        clk;
  logic        reset;
  logic        lch_atbout;
  logic        ctrl_done;
  logic        ctrl_chan_err;
  logic [15:0] ctrl_rdata;
  logic        ctrl_go;
  logic        ctrl_lock;
  dcd_chan_t   ctrl_chan;
  logic [11:0] ctrl_addr;
  dcd_opcode_e ctrl_opcode;
  logic [15:0] ctrl_wdata;
  logic        user_busy;

  row_t        chan_rows [`DCD_NUM_CHANNELS];
  logic [15:0] regs      [`DCD_NUM_CHANNELS][NUM_REGS];
  logic [15:0] init_regs [`DCD_NUM_CHANNELS][NUM_REGS];
  int          proto_errors = 0;
  int          busy_errors  = 0;
  int          busy_falls   = 0;

  dcd_clock_gen clock_gen_i (
    .clk   (clk),
    .reset (reset)
  );

  dcd_calibration_top dut_i (
    .clk           (clk),
    .reset         (reset),
    .lch_atbout    (lch_atbout),
    .ctrl_done     (ctrl_done),
    .ctrl_chan_err (ctrl_chan_err),
    .ctrl_rdata    (ctrl_rdata),
    .ctrl_go       (ctrl_go),
    .ctrl_lock     (ctrl_lock),
    .ctrl_chan     (ctrl_chan),
    .ctrl_addr     (ctrl_addr),
    .ctrl_opcode   (ctrl_opcode),
    .ctrl_wdata    (ctrl_wdata),
    .user_busy     (user_busy)
  );

  task automatic set_row(input int idx, input logic req, input logic id, input logic err,
                         input logic [2:0] thr, input logic stuck, input logic [2:0] exp_t);
    chan_rows[idx] = {req, id, err, thr, stuck, exp_t};
  endtask

  // Expected tune is thr for 3..7, thr+1 for 0..2 and 0 when stuck high
  task automatic fill_table();
    set_row(0, 1'b1, 1'b1, 1'b0, 3'd7, 1'b0, 3'd7);
    set_row(1, 1'b1, 1'b1, 1'b0, 3'd1, 1'b0, 3'd2);
    set_row(2, 1'b0, 1'b1, 1'b0, 3'd4, 1'b0, 3'd0);
    set_row(3, 1'b1, 1'b0, 1'b0, 3'd4, 1'b0, 3'd0);
    set_row(4, 1'b1, 1'b1, 1'b1, 3'd4, 1'b0, 3'd0);
    set_row(5, 1'b1, 1'b1, 1'b0, 3'd2, 1'b1, 3'd0);
  endtask

  function automatic logic row_calibrated(input int ch);
    return chan_rows[ch].request && chan_rows[ch].id && !chan_rows[ch].chan_err;
  endfunction

  function automatic string reg_name(input int idx);
    case (idx)
      IDX_REQUEST: return "request";
      IDX_ID:      return "id";
      IDX_CLK_MON: return "clk_mon";
      IDX_LST:     return "lst";
      default:     return "tune";
    endcase
  endfunction

  // Only the target fields of a calibrated channel may move
  function automatic logic [15:0] expected_reg(input int ch, input int idx);
    logic [15:0] v;
    v = init_regs[ch][idx];
    if (row_calibrated(ch)) begin
      case (idx)
        IDX_CLK_MON: v[`DCD_CLK_MON_BIT] = 1'b0;
        IDX_LST:     v[`DCD_LST_HI:`DCD_LST_LO] = `DCD_LST_OFF;
        IDX_TUNE:    v[`DCD_TUNE_HI:`DCD_TUNE_LO] = chan_rows[ch].exp_tune;
        default:     v = init_regs[ch][idx];
      endcase
    end
    return v;
  endfunction

  // Register bus model and comparator driven on the falling edge
  initial begin : bus_model
    int          c;
    int          i;
    int          delay_left;
    logic        pending;
    int          acc_chan;
    int          acc_idx;
    dcd_opcode_e acc_op;
    logic [15:0] acc_wdata;
    int          last_chan;
    logic [2:0]  tune_field;
    void'($urandom(32'hf3ec_5bc2));
    fill_table();
    for (c = 0; c < `DCD_NUM_CHANNELS; c++) begin
      for (i = 0; i < NUM_REGS; i++) begin
        regs[c][i] = 16'($urandom);
      end
      regs[c][IDX_REQUEST][`DCD_REQUEST_BIT] = chan_rows[c].request;
      regs[c][IDX_ID][`DCD_ID_TX_BIT]        = chan_rows[c].id;
      for (i = 0; i < NUM_REGS; i++) begin
        init_regs[c][i] = regs[c][i];
      end
    end
    lch_atbout    = 1'b0;
    ctrl_done     = 1'b0;
    ctrl_chan_err = 1'b0;
    ctrl_rdata    = '0;
    pending       = 1'b0;
    delay_left    = 0;
    acc_chan      = 0;
    acc_idx       = 0;
    acc_op        = op_read;
    acc_wdata     = '0;
    last_chan     = 0;
    forever begin
      @(negedge clk);
      ctrl_done = 1'b0;
      if (pending) begin
        if (delay_left > 1) begin
          delay_left--;
        end else begin
          pending   = 1'b0;
          ctrl_done = 1'b1;
          if (int'(ctrl_chan) != acc_chan) begin
            $display("** Error at %0d ns: ctrl_chan = %0d, expected %0d", $time, ctrl_chan,
                     acc_chan);
            proto_errors++;
          end
          if (acc_op == op_read) begin
            ctrl_rdata = regs[acc_chan][acc_idx];
          end else begin
            regs[acc_chan][acc_idx] = acc_wdata;
          end
        end
      end
      if (!reset && ctrl_go === 1'b1) begin
        if (user_busy !== 1'b1) begin
          $display("Bus access started at %0d ns after busy fell", $time);
          proto_errors++;
        end
        if (pending) begin
          $display("Bus access started at %0d ns while another was outstanding", $time);
          proto_errors++;
        end
        if (int'(ctrl_chan) >= `DCD_NUM_CHANNELS || int'(ctrl_addr) >= NUM_REGS) begin
          $display("Bus access at %0d ns to channel %0d address %h is out of range", $time,
                   ctrl_chan, ctrl_addr);
          proto_errors++;
        end else begin
          if (int'(ctrl_chan) < last_chan) begin
            $display("** Error at %0d ns: ctrl_chan = %0d, expected >= %0d", $time,
                     ctrl_chan, last_chan);
            proto_errors++;
          end
          last_chan = int'(ctrl_chan);
          if (ctrl_opcode == op_write) begin
            if (ctrl_lock !== 1'b1) begin
              $display("** Error at %0d ns: ctrl_lock = %b, expected 1", $time, ctrl_lock);
              proto_errors++;
            end
            if (int'(ctrl_addr) < IDX_CLK_MON || !row_calibrated(int'(ctrl_chan))) begin
              $display("Write at %0d ns to channel %0d %s is not allowed", $time, ctrl_chan,
                       reg_name(int'(ctrl_addr)));
              proto_errors++;
            end
          end
          pending    = 1'b1;
          delay_left = 1 + int'($urandom % 5);
          acc_chan   = int'(ctrl_chan);
          acc_idx    = int'(ctrl_addr);
          acc_op     = ctrl_opcode;
          acc_wdata  = ctrl_wdata;
        end
      end
      // Chan_err and comparator follow the channel on the bus
      if (int'(ctrl_chan) < `DCD_NUM_CHANNELS) begin
        c             = int'(ctrl_chan);
        tune_field    = regs[c][IDX_TUNE][`DCD_TUNE_HI:`DCD_TUNE_LO];
        ctrl_chan_err = chan_rows[c].chan_err;
        lch_atbout    = (tune_field > chan_rows[c].threshold) || chan_rows[c].stuck;
      end else begin
        ctrl_chan_err = 1'b0;
        lch_atbout    = 1'b0;
      end
    end
  end

  initial begin : busy_monitor
    logic prev_busy;
    prev_busy = 1'b1;
    forever begin
      @(negedge clk);
      if (!reset) begin
        if (prev_busy === 1'b1 && user_busy === 1'b0) begin
          busy_falls++;
        end else if (prev_busy === 1'b0 && user_busy !== 1'b0) begin
          $display("** Error at %0d ns: user_busy = %b, expected 0", $time, user_busy);
          busy_errors++;
        end
        prev_busy = user_busy;
      end
    end
  end

  initial begin : main_seq
    int          ch;
    int          idx;
    int          row_errs;
    int          tests_run;
    int          tests_failed;
    logic [15:0] got;
    logic [15:0] exp;
    tests_run    = 0;
    tests_failed = 0;
    wait (reset === 1'b0);
    @(negedge clk);
    if (user_busy !== 1'b1) begin
      $display("** Error at %0d ns: user_busy = %b, expected 1", $time, user_busy);
      busy_errors++;
    end
    while (user_busy !== 1'b0) begin
      @(negedge clk);
    end
    // Idle window to catch late bus traffic or a second busy pulse
    repeat (QUIET_CYCLES) @(negedge clk);
    tests_run++;
    if (busy_errors == 0 && busy_falls == 1) begin
      $display("Test busy: ok, busy fell once");
    end else begin
      $display("Test busy: FAILED, busy fell %0d times", busy_falls);
      tests_failed++;
    end

    for (ch = 0; ch < `DCD_NUM_CHANNELS; ch++) begin
      row_errs = 0;
      for (idx = 0; idx < NUM_REGS; idx++) begin
        got = regs[ch][idx];
        exp = expected_reg(ch, idx);
        if (got !== exp) begin
          $display("** Error at %0d ns: channel %0d %s = %h, expected %h", $time, ch,
                   reg_name(idx), got, exp);
          row_errs++;
        end
      end
      tests_run++;
      if (row_errs == 0) begin
        $display("Test channel %0d: ok, %s", ch, row_calibrated(ch) ? "calibrated" : "skipped");
      end else begin
        $display("Test channel %0d: FAILED, %0d wrong registers", ch, row_errs);
        tests_failed++;
      end
    end

    tests_run++;
    if (proto_errors == 0) begin
      $display("Test bus protocol: ok");
    end else begin
      $display("Test bus protocol: FAILED, %0d errors", proto_errors);
      tests_failed++;
    end

    $display("Tests run: %0d, passed: %0d, failed: %0d", tests_run, tests_run - tests_failed,
             tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout after %0d cycles, calibration did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- all.f
+incdir+rtl
rtl/dcd_bus_pkg.sv
rtl/dcd_cal_pkg.sv
rtl/dcd_step_if.sv
rtl/dcd_tune_if.sv
rtl/dcd_sequencer.sv
rtl/dcd_tune_search.sv
rtl/dcd_bus_master.sv
rtl/dcd_calibration_top.sv
dv/dcd_clock_gen.sv
dv/dcd_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the DCD calibration testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f all.f --top-module dcd_tb -o dcd_sim || exit 1
out=$(./obj_dir/dcd_sim)
echo "$out"
echo "$out" | grep -q "All tests passed" && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
